//--- project.f
+incdir+common
common/dcache_pkg.sv
dcache/plru_table.sv
dcache/dcache_arrays.sv
dcache/dcache_ctrl.sv
dcache/dcache_top.sv
tb/mem_model.sv
tb/tb_dcache.sv

//--- Makefile
TOP := tb_dcache

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- tb/tb_dcache.sv
`include "dcache_defs.svh"

module tb_dcache;
    timeunit 1ns;
    timeprecision 100ps;

    logic                     clk;
    logic                     reset;
    logic                     req_valid;
    dcache_pkg::cpu_req_t     req;
    logic                     busy;
    logic [`DATA_WIDTH-1:0]   rdata;
    logic                     mem_rd_req;
    logic [31:0]              mem_rd_addr;
    logic                     mem_rd_rdy;
    logic                     mem_ret_valid;
    logic [`LINE_WIDTH-1:0]   mem_ret_data;
    logic                     mem_wr_req;
    dcache_pkg::wb_line_t     mem_wr_line;
    logic                     mem_wr_rdy;
    logic                     mem_wr_valid;

    logic [31:0]            shadow [logic [29:0]];
    logic [32:0]            expect_q [$];  // bit 32 set for a load
    int                     rd_count = 0;
    int                     wr_count = 0;
    logic [31:0]            last_rd_addr;
    dcache_pkg::wb_line_t   last_wb;
    logic                   busy_prev = 1'b0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    dcache_top uut (.*);

    mem_model u_mem (.*);

    task automatic abort_run(string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(string name, logic [127:0] actual, logic [127:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    function automatic logic [31:0] expected_load(logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
                                                logic [3:0] strb);
        logic [31:0] res;
        for (int b = 0; b < 4; b++) begin
            res[8*b +: 8] = strb[b] ? wdata[8*b +: 8] : old[8*b +: 8];
        end
        return res;
    endfunction

    function automatic logic [31:0] addr_of(logic [`TAG_WIDTH-1:0] tag,
                                            logic [`INDEX_WIDTH-1:0] idx, logic [1:0] word);
        return {tag, idx, word, 2'b00};
    endfunction

    function automatic logic [`LINE_WIDTH-1:0] shadow_line(logic [31:0] base);
        logic [`LINE_WIDTH-1:0] line;
        for (int k = 0; k < `WORDS_PER_LINE; k++) begin
            line[`DATA_WIDTH*k +: `DATA_WIDTH] = expected_load(base + 32'(4 * k));
        end
        return line;
    endfunction

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > 200) begin
                abort_run("timeout: cache stayed busy for 200 cycles");
            end
        end
    endtask

    // called at edge + 1 with the cache idle
    task automatic issue(dcache_pkg::mem_op_e op, logic [31:0] addr, logic [31:0] wdata,
                         logic [3:0] wstrb);
        req.op     = op;
        req.tag    = addr[31 -: `TAG_WIDTH];
        req.index  = addr[`OFFSET_WIDTH +: `INDEX_WIDTH];
        req.offset = addr[`OFFSET_WIDTH-1:0];
        req.wdata  = wdata;
        req.wstrb  = wstrb;
        req_valid  = 1'b1;
        if (op == dcache_pkg::op_load) begin
            expect_q.push_back({1'b1, expected_load(addr)});
        end else begin
            shadow[addr[31:2]] = merge_bytes(expected_load(addr), wdata, wstrb);
            expect_q.push_back({1'b0, 32'h0});
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        wait_idle();
    endtask

    // compare at the first idle cycle of each request
    always @(negedge clk) begin
        logic [32:0] entry;
        if (!reset) begin
            if (busy_prev && !busy) begin
                if (expect_q.size() == 0) begin
                    abort_run("cache finished a request that was never issued");
                end else begin
                    entry = expect_q.pop_front();
                    if (entry[32]) begin
                        check_value("rdata", rdata, entry[31:0]);
                    end
                end
            end
            busy_prev = busy;
        end
    end

    always @(negedge clk) begin
        if (!reset && mem_rd_req && mem_rd_rdy) begin
            rd_count++;
            last_rd_addr = mem_rd_addr;
        end
        if (!reset && mem_wr_req && mem_wr_rdy) begin
            wr_count++;
            last_wb = mem_wr_line;
        end
    end

    initial begin
        int                        rd_before;
        int                        wr_before;
        logic [31:0]               a;
        logic [31:0]               b;
        logic [31:0]               c;
        logic [`TAG_WIDTH-1:0]     tag;
        logic [`INDEX_WIDTH-1:0]   idx;
        logic [1:0]                word;
        void'($urandom(32'h2c5b));
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        check_value("busy", busy, 0);
        check_value("mem_rd_req", mem_rd_req, 0);
        check_value("mem_wr_req", mem_wr_req, 0);

        // miss then hit on one line
        a = addr_of(20'h00012, 8'h10, 2'd0);
        rd_before = rd_count;
        wr_before = wr_count;
        issue(dcache_pkg::op_load, a + 8, 32'h0, 4'h0);
        check_value("mem_rd_count", rd_count, rd_before + 1);
        check_value("mem_rd_addr", last_rd_addr, a);
        issue(dcache_pkg::op_load, a + 4, 32'h0, 4'h0);
        check_value("mem_rd_count", rd_count, rd_before + 1);

        // partial store hit
        issue(dcache_pkg::op_store, a + 8, 32'hdead_beef, 4'b0101);
        issue(dcache_pkg::op_load, a + 8, 32'h0, 4'h0);
        check_value("mem_rd_count", rd_count, rd_before + 1);
        check_value("mem_wr_count", wr_count, wr_before);

        // dirty eviction, A is least recent
        a = addr_of(20'h00001, 8'h20, 2'd0);
        b = addr_of(20'h00002, 8'h20, 2'd0);
        c = addr_of(20'h00003, 8'h20, 2'd0);
        issue(dcache_pkg::op_store, a + 4, 32'h1111_2222, 4'hf);
        issue(dcache_pkg::op_store, b + 8, 32'h3333_4444, 4'b1100);
        wr_before = wr_count;
        issue(dcache_pkg::op_load, c, 32'h0, 4'h0);
        check_value("mem_wr_count", wr_count, wr_before + 1);
        check_value("mem_wr_line.addr", last_wb.addr, a);
        check_value("mem_wr_line.line", last_wb.line, shadow_line(a));
        issue(dcache_pkg::op_load, a + 4, 32'h0, 4'h0);

        // replacement order
        a = addr_of(20'h00004, 8'h30, 2'd0);
        b = addr_of(20'h00005, 8'h30, 2'd0);
        c = addr_of(20'h00006, 8'h30, 2'd0);
        issue(dcache_pkg::op_load, a, 32'h0, 4'h0);
        issue(dcache_pkg::op_store, a, 32'haaaa_5555, 4'b0011);
        issue(dcache_pkg::op_load, b + 12, 32'h0, 4'h0);
        issue(dcache_pkg::op_store, b + 12, 32'h0f0f_f0f0, 4'b1000);
        issue(dcache_pkg::op_load, a, 32'h0, 4'h0);
        wr_before = wr_count;
        issue(dcache_pkg::op_load, c, 32'h0, 4'h0);
        check_value("mem_wr_count", wr_count, wr_before + 1);
        check_value("mem_wr_line.addr", last_wb.addr, b);
        check_value("mem_wr_line.line", last_wb.line, shadow_line(b));

        // 16 lines over 4 sets
        for (int n = 0; n < 300; n++) begin
            tag  = `TAG_WIDTH'(20'h00100 + $urandom_range(3, 0));
            idx  = `INDEX_WIDTH'(8'h40 + $urandom_range(3, 0));
            word = 2'($urandom_range(3, 0));
            a    = addr_of(tag, idx, word);
            if ($urandom_range(1, 0) == 1) begin
                issue(dcache_pkg::op_store, a, $urandom, 4'($urandom_range(15, 0)));
            end else begin
                issue(dcache_pkg::op_load, a, 32'h0, 4'h0);
            end
        end

        @(posedge clk);
        #1;
        if (expect_q.size() != 0) begin
            abort_run("some requests never completed");
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- tb/mem_model.sv
`include "dcache_defs.svh"

module mem_model (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     mem_rd_req,
    input  logic [31:0]              mem_rd_addr,
    output logic                     mem_rd_rdy,
    output logic                     mem_ret_valid,
    output logic [`LINE_WIDTH-1:0]   mem_ret_data,
    input  logic                     mem_wr_req,
    input  dcache_pkg::wb_line_t     mem_wr_line,
    output logic                     mem_wr_rdy,
    output logic                     mem_wr_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] store [logic [29:0]];  // word address -> data

    function automatic logic [31:0] read_word(logic [31:0] addr);
        if (store.exists(addr[31:2])) begin
            return store[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ 32'h5a5a_0000;  // never written
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic serve_read();
        logic [31:0]              base;
        logic [`LINE_WIDTH-1:0]   line;
        idle_cycles($urandom_range(5, 0));
        base = mem_rd_addr;
        for (int k = 0; k < `WORDS_PER_LINE; k++) begin
            line[`DATA_WIDTH*k +: `DATA_WIDTH] = read_word(base + 32'(4 * k));
        end
        mem_rd_rdy = 1'b1;
        @(posedge clk);
        #1;
        mem_rd_rdy = 1'b0;
        idle_cycles($urandom_range(5, 0));
        mem_ret_data  = line;
        mem_ret_valid = 1'b1;
        @(posedge clk);
        #1;
        mem_ret_valid = 1'b0;
    endtask

    task automatic serve_write();
        dcache_pkg::wb_line_t wb;
        idle_cycles($urandom_range(5, 0));
        wb = mem_wr_line;  // held for the whole request
        mem_wr_rdy = 1'b1;
        @(posedge clk);
        #1;
        mem_wr_rdy = 1'b0;
        for (int k = 0; k < `WORDS_PER_LINE; k++) begin
            store[wb.addr[31:2] + 30'(k)] = wb.line[`DATA_WIDTH*k +: `DATA_WIDTH];
        end
        idle_cycles($urandom_range(5, 0));
        mem_wr_valid = 1'b1;
        @(posedge clk);
        #1;
        mem_wr_valid = 1'b0;
    endtask

    initial begin
        mem_rd_rdy    = 1'b0;
        mem_ret_valid = 1'b0;
        mem_ret_data  = '0;
        mem_wr_rdy    = 1'b0;
        mem_wr_valid  = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            // write-back always comes before the refill of a dirty miss
            if (!reset && mem_wr_req) begin
                serve_write();
            end else if (!reset && mem_rd_req) begin
                serve_read();
            end
        end
    end

endmodule

//--- dcache/dcache_top.sv
`include "dcache_defs.svh"

module dcache_top (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req_valid,
    input  dcache_pkg::cpu_req_t     req,
    output logic                     busy,
    output logic [`DATA_WIDTH-1:0]   rdata,
    output logic                     mem_rd_req,
    output logic [31:0]              mem_rd_addr,
    input  logic                     mem_rd_rdy,
    input  logic                     mem_ret_valid,
    input  logic [`LINE_WIDTH-1:0]   mem_ret_data,
    output logic                     mem_wr_req,
    output dcache_pkg::wb_line_t     mem_wr_line,
    input  logic                     mem_wr_rdy,
    input  logic                     mem_wr_valid
);

    logic                                     rd_en;
    logic [`INDEX_WIDTH-1:0]                  rd_index;
    dcache_pkg::tag_entry_t [`ASSOC_NUM-1:0]  way_tags;
    logic [`ASSOC_NUM-1:0]                    way_dirty;
    logic [`ASSOC_NUM-1:0][`LINE_WIDTH-1:0]   way_lines;
    logic                                     fill_we;
    logic                                     store_we;
    logic                                     wr_way;
    logic [`INDEX_WIDTH-1:0]                  wr_index;
    logic [`TAG_WIDTH-1:0]                    fill_tag;
    logic [`LINE_WIDTH-1:0]                   fill_line;
    logic [1:0]                               store_word;
    logic [`DATA_WIDTH-1:0]                   store_data;
    logic                                     plru_update;
    logic                                     hit_way;
    logic                                     victim_way;

    dcache_ctrl u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .busy          (busy),
        .rdata         (rdata),
        .mem_rd_req    (mem_rd_req),
        .mem_rd_addr   (mem_rd_addr),
        .mem_rd_rdy    (mem_rd_rdy),
        .mem_ret_valid (mem_ret_valid),
        .mem_ret_data  (mem_ret_data),
        .mem_wr_req    (mem_wr_req),
        .mem_wr_line   (mem_wr_line),
        .mem_wr_rdy    (mem_wr_rdy),
        .mem_wr_valid  (mem_wr_valid),
        .rd_en         (rd_en),
        .rd_index      (rd_index),
        .way_tags      (way_tags),
        .way_dirty     (way_dirty),
        .way_lines     (way_lines),
        .fill_we       (fill_we),
        .store_we      (store_we),
        .wr_way        (wr_way),
        .wr_index      (wr_index),
        .fill_tag      (fill_tag),
        .fill_line     (fill_line),
        .store_word    (store_word),
        .store_data    (store_data),
        .plru_update   (plru_update),
        .hit_way       (hit_way),
        .victim_way    (victim_way)
    );

    dcache_arrays u_arrays (
        .clk        (clk),
        .reset      (reset),
        .rd_en      (rd_en),
        .rd_index   (rd_index),
        .fill_we    (fill_we),
        .store_we   (store_we),
        .wr_way     (wr_way),
        .wr_index   (wr_index),
        .fill_tag   (fill_tag),
        .fill_line  (fill_line),
        .store_word (store_word),
        .store_data (store_data),
        .way_tags   (way_tags),
        .way_dirty  (way_dirty),
        .way_lines  (way_lines)
    );

    plru_table u_plru (
        .clk        (clk),
        .reset      (reset),
        .update     (plru_update),
        .index      (wr_index),  // registered request index
        .used_way   (hit_way),
        .victim_way (victim_way)
    );

endmodule

//--- dcache/dcache_ctrl.sv
`include "dcache_defs.svh"

module dcache_ctrl (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     req_valid,
    input  dcache_pkg::cpu_req_t                     req,
    output logic                                     busy,
    output logic [`DATA_WIDTH-1:0]                   rdata,
    output logic                                     mem_rd_req,
    output logic [31:0]                              mem_rd_addr,
    input  logic                                     mem_rd_rdy,
    input  logic                                     mem_ret_valid,
    input  logic [`LINE_WIDTH-1:0]                   mem_ret_data,
    output logic                                     mem_wr_req,
    output dcache_pkg::wb_line_t                     mem_wr_line,
    input  logic                                     mem_wr_rdy,
    input  logic                                     mem_wr_valid,
    output logic                                     rd_en,
    output logic [`INDEX_WIDTH-1:0]                  rd_index,
    input  dcache_pkg::tag_entry_t [`ASSOC_NUM-1:0]  way_tags,
    input  logic [`ASSOC_NUM-1:0]                    way_dirty,
    input  logic [`ASSOC_NUM-1:0][`LINE_WIDTH-1:0]   way_lines,
    output logic                                     fill_we,
    output logic                                     store_we,
    output logic                                     wr_way,
    output logic [`INDEX_WIDTH-1:0]                  wr_index,
    output logic [`TAG_WIDTH-1:0]                    fill_tag,
    output logic [`LINE_WIDTH-1:0]                   fill_line,
    output logic [1:0]                               store_word,
    output logic [`DATA_WIDTH-1:0]                   store_data,
    output logic                                     plru_update,
    output logic                                     hit_way,
    input  logic                                     victim_way
);

    dcache_pkg::cache_state_e  state;
    dcache_pkg::cache_state_e  state_next;
    dcache_pkg::cpu_req_t      req_q;
    logic                      pending;  // request held, not yet answered
    logic                      accept;
    logic [`ASSOC_NUM-1:0]     hit;
    logic                      hit_any;
    logic [`DATA_WIDTH-1:0]    hit_word;
    logic [`DATA_WIDTH-1:0]    merged;
    dcache_pkg::tag_entry_t    victim_tag;

    assign busy   = pending || (state != dcache_pkg::lookup);
    assign accept = req_valid && !busy;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b1;
        end else if (plru_update) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
        end
    end

    // arrays are read on acceptance and again once the refill has landed
    assign rd_en    = accept || (state == dcache_pkg::refill_done);
    assign rd_index = (state == dcache_pkg::refill_done) ? req_q.index : req.index;

    always_comb begin
        for (int w = 0; w < `ASSOC_NUM; w++) begin
            hit[w] = way_tags[w].valid && (way_tags[w].tag == req_q.tag);
        end
    end

    assign hit_any  = |hit;
    assign hit_way  = hit[1];
    assign hit_word = way_lines[hit_way][`DATA_WIDTH*req_q.offset[`OFFSET_WIDTH-1:2] +: `DATA_WIDTH];

    // byte lanes not strobed keep the cached value
    always_comb begin
        for (int b = 0; b < `WSTRB_WIDTH; b++) begin
            merged[8*b +: 8] = req_q.wstrb[b] ? req_q.wdata[8*b +: 8] : hit_word[8*b +: 8];
        end
    end

    assign plru_update = (state == dcache_pkg::lookup) && pending && hit_any;

    always_ff @(posedge clk) begin
        if (plru_update && (req_q.op == dcache_pkg::op_load)) begin
            rdata <= hit_word;
        end
    end

    // writes into the arrays
    assign fill_we    = (state == dcache_pkg::refill) && mem_ret_valid;
    assign store_we   = plru_update && (req_q.op == dcache_pkg::op_store);
    assign wr_way     = (state == dcache_pkg::refill) ? victim_way : hit_way;
    assign wr_index   = req_q.index;
    assign fill_tag   = req_q.tag;
    assign fill_line  = mem_ret_data;
    assign store_word = req_q.offset[`OFFSET_WIDTH-1:2];
    assign store_data = merged;

    // victim entry stays put until refill_done rereads the set
    assign victim_tag       = way_tags[victim_way];
    assign mem_wr_req       = (state == dcache_pkg::miss_dirty);
    assign mem_wr_line.addr = {victim_tag.tag, req_q.index, {`OFFSET_WIDTH{1'b0}}};
    assign mem_wr_line.line = way_lines[victim_way];
    assign mem_rd_req       = (state == dcache_pkg::miss_clean);
    assign mem_rd_addr      = {req_q.tag, req_q.index, {`OFFSET_WIDTH{1'b0}}};

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dcache_pkg::lookup;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            dcache_pkg::lookup: begin
                if (pending && !hit_any) begin
                    if (victim_tag.valid && way_dirty[victim_way]) begin
                        state_next = dcache_pkg::miss_dirty;
                    end else begin
                        state_next = dcache_pkg::miss_clean;
                    end
                end
            end
            dcache_pkg::miss_dirty: begin
                if (mem_wr_rdy) begin
                    state_next = dcache_pkg::write_back;
                end
            end
            dcache_pkg::write_back: begin
                if (mem_wr_valid) begin  // write complete
                    state_next = dcache_pkg::miss_clean;
                end
            end
            dcache_pkg::miss_clean: begin
                if (mem_rd_rdy) begin
                    state_next = dcache_pkg::refill;
                end
            end
            dcache_pkg::refill: begin
                if (mem_ret_valid) begin
                    state_next = dcache_pkg::refill_done;
                end
            end
            dcache_pkg::refill_done: begin
                state_next = dcache_pkg::lookup;  // retry, now hits
            end
            default: begin
                state_next = dcache_pkg::lookup;
            end
        endcase
    end

    // memory requests are levels held until taken
    a_rd_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_rd_req && !mem_rd_rdy |=> mem_rd_req);

    a_wr_req_held: assert property (@(posedge clk) disable iff (reset)
        mem_wr_req && !mem_wr_rdy |=> mem_wr_req);

    // the CPU request stays held for the whole miss
    a_held_in_miss: assert property (@(posedge clk) disable iff (reset)
        (state != dcache_pkg::lookup) |-> pending);

endmodule

//--- dcache/dcache_arrays.sv
`include "dcache_defs.svh"

module dcache_arrays (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     rd_en,
    input  logic [`INDEX_WIDTH-1:0]                  rd_index,
    input  logic                                     fill_we,
    input  logic                                     store_we,
    input  logic                                     wr_way,
    input  logic [`INDEX_WIDTH-1:0]                  wr_index,
    input  logic [`TAG_WIDTH-1:0]                    fill_tag,
    input  logic [`LINE_WIDTH-1:0]                   fill_line,
    input  logic [1:0]                               store_word,
    input  logic [`DATA_WIDTH-1:0]                   store_data,
    output dcache_pkg::tag_entry_t [`ASSOC_NUM-1:0]  way_tags,
    output logic [`ASSOC_NUM-1:0]                    way_dirty,
    output logic [`ASSOC_NUM-1:0][`LINE_WIDTH-1:0]   way_lines
);

    localparam int num_sets = 1 << `INDEX_WIDTH;

    logic [`TAG_WIDTH-1:0]   tag_mem  [`ASSOC_NUM][num_sets];
    logic [`LINE_WIDTH-1:0]  data_mem [`ASSOC_NUM][num_sets];
    logic [`ASSOC_NUM-1:0][num_sets-1:0] valid_bits;
    logic [`ASSOC_NUM-1:0][num_sets-1:0] dirty_bits;

    // valid and dirty per way and set
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (fill_we) begin
            valid_bits[wr_way][wr_index] <= 1'b1;
            dirty_bits[wr_way][wr_index] <= 1'b0;  // fresh line from memory
        end else if (store_we) begin
            dirty_bits[wr_way][wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[wr_way][wr_index]  <= fill_tag;
            data_mem[wr_way][wr_index] <= fill_line;
        end else if (store_we) begin
            for (int k = 0; k < `WORDS_PER_LINE; k++) begin
                if (store_word == k) begin  // word enable
                    data_mem[wr_way][wr_index][`DATA_WIDTH*k +: `DATA_WIDTH] <= store_data;
                end
            end
        end
    end

    // registered read of every way
    always_ff @(posedge clk) begin
        if (rd_en) begin
            for (int w = 0; w < `ASSOC_NUM; w++) begin
                way_tags[w].tag   <= tag_mem[w][rd_index];
                way_tags[w].valid <= valid_bits[w][rd_index];
                way_dirty[w]      <= dirty_bits[w][rd_index];
                way_lines[w]      <= data_mem[w][rd_index];
            end
        end
    end

    a_one_writer: assert property (@(posedge clk) disable iff (reset)
        !(fill_we && store_we));

endmodule

//--- dcache/plru_table.sv
`include "dcache_defs.svh"

module plru_table (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     update,
    input  logic [`INDEX_WIDTH-1:0]  index,
    input  logic                     used_way,
    output logic                     victim_way
);

    localparam int num_sets = 1 << `INDEX_WIDTH;

    logic [num_sets-1:0] mru;  // most recently used way per set

    always_ff @(posedge clk) begin
        if (reset) begin
            mru <= '0;
        end else if (update) begin
            mru[index] <= used_way;
        end
    end

    // evict the way not touched last
    assign victim_way = ~mru[index];

endmodule

//--- common/dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

    typedef enum logic {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    typedef struct packed {
        mem_op_e                   op;
        logic [`TAG_WIDTH-1:0]     tag;
        logic [`INDEX_WIDTH-1:0]   index;
        logic [`OFFSET_WIDTH-1:0]  offset;
        logic [`DATA_WIDTH-1:0]    wdata;
        logic [`WSTRB_WIDTH-1:0]   wstrb;  // one bit per byte lane
    } cpu_req_t;

    typedef struct packed {
        logic [`TAG_WIDTH-1:0] tag;
        logic                  valid;
    } tag_entry_t;

    // line leaving the cache on eviction
    typedef struct packed {
        logic [31:0]             addr;  // offset bits zero
        logic [`LINE_WIDTH-1:0]  line;
    } wb_line_t;

    typedef enum logic [2:0] {
        lookup      = 3'd0,
        miss_dirty  = 3'd1,
        write_back  = 3'd2,
        miss_clean  = 3'd3,
        refill      = 3'd4,
        refill_done = 3'd5
    } cache_state_e;

endpackage

//--- common/dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// data path
`define DATA_WIDTH     32
`define WORDS_PER_LINE 4
`define LINE_WIDTH     128
`define WSTRB_WIDTH    4

// geometry, 2 ways of 256 sets
`define ASSOC_NUM      2
`define INDEX_WIDTH    8
`define OFFSET_WIDTH   4  // byte offset in a line
`define TAG_WIDTH      20

`endif
